//--- include/div_cfg.svh
// configuration macros for the integer divide unit
// include this wherever widths, step counts or testbench limits are needed

`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// operand width in bits
`define DIV_WIDTH 32

// one quotient bit per iteration, so the step count tracks the width
`define DIV_STEPS `DIV_WIDTH

// cycle limit for any single wait in the testbench
`define DIV_TB_TIMEOUT 200

`endif

//--- design/div_pkg.sv
// shared types for the divide unit
// reach these by scoped names, e.g. div_pkg::word_t

`include "div_cfg.svh"

package div_pkg;

  // operand, quotient or remainder
  typedef logic [`DIV_WIDTH-1:0] word_t;

  // packed response, remainder in the upper word and quotient in the lower
  typedef logic [2*`DIV_WIDTH-1:0] result_t;

  // remainder/quotient accumulator plus one sign bit on top
  typedef logic [2*`DIV_WIDTH:0] acc_t;

  // iteration counter, counts down to zero
  typedef logic [$clog2(`DIV_STEPS)-1:0] count_t;

  // request function
  typedef enum logic {
    fn_unsigned = 1'b0,
    fn_signed   = 1'b1
  } div_fn_t;

  // iterative core control
  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    done = 2'd2
  } core_state_t;

endpackage

//--- design/div_if.sv
// val/rdy channels carrying operand and result magnitudes with sign flags
// src drives val and the payload, dst drives rdy

`timescale 1ns/1ps

`include "div_cfg.svh"

// prep stage to iterative core
interface mag_req_if;
  logic              val;
  logic              rdy;
  div_pkg::word_t    a_mag;
  logic              quot_neg;
  logic              rem_neg;
  div_pkg::word_t    b_mag;

  // a_mag is the dividend, b_mag the divisor
  modport src (output val, output a_mag, output b_mag,
               output quot_neg, output rem_neg, input rdy);
  modport dst (input val, input a_mag, input b_mag,
               input quot_neg, input rem_neg, output rdy);
endinterface

// iterative core to result fixup
interface mag_res_if;
  logic              val;
  logic              rdy;
  div_pkg::word_t    quot_mag;
  div_pkg::word_t    rem_mag;
  // flags travel unchanged from the prep stage
  logic              quot_neg;
  logic              rem_neg;

  modport src (output val, output quot_mag, output rem_mag,
               output quot_neg, output rem_neg, input rdy);
  modport dst (input val, input quot_mag, input rem_mag,
               input quot_neg, input rem_neg, output rdy);
endinterface

//--- design/div_operand_prep.sv
// input stage of the divider: one-entry request register
// turns signed operands into magnitudes and records the result signs

`timescale 1ns/1ps

`include "div_cfg.svh"

module div_operand_prep (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_val,
  input  div_pkg::div_fn_t  req_fn,
  input  div_pkg::word_t    req_a,
  input  div_pkg::word_t    req_b,
  output logic              req_rdy,
  mag_req_if.src            mag
);

  logic           full;
  logic           req_go;
  logic           mag_go;
  logic           a_neg;
  logic           b_neg;
  div_pkg::word_t a_mag_q;
  div_pkg::word_t b_mag_q;
  logic           quot_neg_q;
  logic           rem_neg_q;

  // handshakes on both sides
  assign mag_go  = mag.val && mag.rdy;
  // accept when empty or when the entry leaves this cycle
  assign req_rdy = !full || mag_go;
  assign req_go  = req_val && req_rdy;

  // only signed requests look at the operand sign bits
  assign a_neg = (req_fn == div_pkg::fn_signed) && req_a[`DIV_WIDTH-1];
  assign b_neg = (req_fn == div_pkg::fn_signed) && req_b[`DIV_WIDTH-1];

  // occupancy flag
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (req_go) begin
      full <= 1'b1;
    end else if (mag_go) begin
      full <= 1'b0;
    end
  end

  // payload, loaded only on a transfer
  always_ff @(posedge clk) begin
    if (req_go) begin
      // 0x80000000 maps onto itself, which is the right magnitude
      a_mag_q    <= a_neg ? (~req_a + 1'b1) : req_a;
      b_mag_q    <= b_neg ? (~req_b + 1'b1) : req_b;
      quot_neg_q <= a_neg ^ b_neg;
      rem_neg_q  <= a_neg;
    end
  end

  assign mag.val      = full;
  assign mag.a_mag    = a_mag_q;
  assign mag.b_mag    = b_mag_q;
  assign mag.quot_neg = quot_neg_q;
  assign mag.rem_neg  = rem_neg_q;

  // held entry must not change under back-pressure from the core
  a_mag_hold: assert property (@(posedge clk) disable iff (reset)
    mag.val && !mag.rdy |=> mag.val && $stable(mag.a_mag) && $stable(mag.b_mag)
      && $stable(mag.quot_neg) && $stable(mag.rem_neg));

endmodule

//--- design/div_iter_core.sv
// restoring divider core, one quotient bit per cycle on magnitudes
// accepts in idle, runs DIV_STEPS calc cycles, then holds the result in done

`timescale 1ns/1ps

`include "div_cfg.svh"

module div_iter_core (
  input logic     clk,
  input logic     reset,
  mag_req_if.dst  req,
  mag_res_if.src  res
);

  div_pkg::core_state_t state;
  div_pkg::core_state_t state_next;
  div_pkg::count_t      count;
  logic                 req_go;
  logic                 res_go;
  logic                 last_step;

  div_pkg::acc_t        acc;
  div_pkg::acc_t        divisor;
  div_pkg::acc_t        acc_shift;
  div_pkg::acc_t        acc_diff;
  div_pkg::acc_t        acc_step;
  logic                 quot_neg_q;
  logic                 rem_neg_q;

  // --------------------
  // control
  // --------------------

  assign req_go    = req.val && req.rdy;
  assign res_go    = res.val && res.rdy;
  // counter hits zero on the final shift-subtract
  assign last_step = (state == div_pkg::calc) && (count == '0);

  always_comb begin
    state_next = state;
    case (state)
      div_pkg::idle: begin
        if (req_go) begin
          state_next = div_pkg::calc;
        end
      end
      div_pkg::calc: begin
        if (last_step) begin
          state_next = div_pkg::done;
        end
      end
      div_pkg::done: begin
        // wait here until the fixup stage takes the result
        if (res_go) begin
          state_next = div_pkg::idle;
        end
      end
      default: begin
        state_next = div_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= div_pkg::idle;
      count <= '0;
    end else begin
      state <= state_next;
      if (req_go) begin
        // DIV_STEPS cycles in calc with the last one at count zero
        count <= div_pkg::count_t'(`DIV_STEPS - 1);
      end else if (state == div_pkg::calc) begin
        count <= count - 1'b1;
      end
    end
  end

  // both sides depend on state only
  assign req.rdy = (state == div_pkg::idle);
  assign res.val = (state == div_pkg::done);

  // --------------------
  // datapath
  // --------------------

  // layout is [2W] sign, [2W-1:W] partial remainder, [W-1:0] dividend/quotient
  assign acc_shift = acc << 1;
  assign acc_diff  = acc_shift - divisor;
  // negative difference restores the shifted value and gives quotient bit 0
  // otherwise keep the difference and set quotient bit 1
  assign acc_step  = acc_diff[2*`DIV_WIDTH] ? {acc_shift[2*`DIV_WIDTH:1], 1'b0}
                                            : {acc_diff[2*`DIV_WIDTH:1], 1'b1};

  always_ff @(posedge clk) begin
    if (req_go) begin
      acc        <= {{(`DIV_WIDTH+1){1'b0}}, req.a_mag};
      // divisor lines up with the remainder field
      divisor    <= {1'b0, req.b_mag, {`DIV_WIDTH{1'b0}}};
      quot_neg_q <= req.quot_neg;
      rem_neg_q  <= req.rem_neg;
    end else if (state == div_pkg::calc) begin
      acc <= acc_step;
    end
  end

  // a zero divisor always subtracts and so gives an all-ones quotient with rem = a
  assign res.quot_mag = acc[`DIV_WIDTH-1:0];
  assign res.rem_mag  = acc[2*`DIV_WIDTH-1:`DIV_WIDTH];
  assign res.quot_neg = quot_neg_q;
  assign res.rem_neg  = rem_neg_q;

  // finished result stays put while the fixup stage stalls
  res_hold: assert property (@(posedge clk) disable iff (reset)
    res.val && !res.rdy |=> res.val && $stable(res.quot_mag) && $stable(res.rem_mag)
      && $stable(res.quot_neg) && $stable(res.rem_neg));

  // result appears exactly after the full run of calc cycles
  val_after_steps: assert property (@(posedge clk) disable iff (reset)
    req_go |=> !res.val [*`DIV_STEPS] ##1 res.val);

endmodule

//--- design/div_result_fixup.sv
// output stage of the divider: applies result signs
// one-entry buffer that holds the response until the consumer takes it

`timescale 1ns/1ps

module div_result_fixup (
  input  logic               clk,
  input  logic               reset,
  input  logic               resp_rdy,
  mag_res_if.dst             mag,
  output logic               resp_val,
  output div_pkg::result_t   resp_result
);

  logic           full;
  logic           mag_go;
  logic           resp_go;
  div_pkg::word_t quot_q;
  div_pkg::word_t rem_q;

  // handshakes
  assign resp_go = resp_val && resp_rdy;
  // take a new result when empty or when the held one leaves now
  assign mag.rdy = !full || resp_go;
  assign mag_go  = mag.val && mag.rdy;

  // occupancy flag
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (mag_go) begin
      full <= 1'b1;
    end else if (resp_go) begin
      full <= 1'b0;
    end
  end

  // sign fixup happens on the way in
  always_ff @(posedge clk) begin
    if (mag_go) begin
      quot_q <= mag.quot_neg ? (~mag.quot_mag + 1'b1) : mag.quot_mag;
      rem_q  <= mag.rem_neg ? (~mag.rem_mag + 1'b1) : mag.rem_mag;
    end
  end

  assign resp_val    = full;
  // remainder high, quotient low
  assign resp_result = {rem_q, quot_q};

  // response must stay put while the consumer stalls
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result));

endmodule

//--- design/int_div_top.sv
// top level of the 32-bit integer divide unit
// request in, response out, both val/rdy; three pipelined stages inside

`timescale 1ns/1ps

module int_div_top (
  input  logic              clk,
  input  logic              reset,

  // request channel
  input  logic              req_val,
  output logic              req_rdy,
  input  div_pkg::div_fn_t  req_fn,
  input  div_pkg::word_t    req_a,
  input  div_pkg::word_t    req_b,

  // response channel
  output logic              resp_val,
  input  logic              resp_rdy,
  output div_pkg::result_t  resp_result
);

  // magnitude channels between the stages
  mag_req_if mag_req ();
  mag_res_if mag_res ();

  div_operand_prep i_div_operand_prep (
    .clk     (clk),
    .reset   (reset),
    .req_val (req_val),
    .req_fn  (req_fn),
    .req_a   (req_a),
    .req_b   (req_b),
    .req_rdy (req_rdy),
    .mag     (mag_req.src)
  );

  div_iter_core i_div_iter_core (
    .clk   (clk),
    .reset (reset),
    .req   (mag_req.dst),
    .res   (mag_res.src)
  );

  div_result_fixup i_div_result_fixup (
    .clk         (clk),
    .reset       (reset),
    .resp_rdy    (resp_rdy),
    .mag         (mag_res.dst),
    .resp_val    (resp_val),
    .resp_result (resp_result)
  );

endmodule

//--- verif/int_div_tb.sv
// testbench for the integer divide unit
// directed and xorshift-random val/rdy traffic is checked against a reference model

`timescale 1ns/1ps

`include "div_cfg.svh"

module int_div_tb;

  logic              clk;
  logic              reset;
  logic              req_val;
  logic              req_rdy;
  div_pkg::div_fn_t  req_fn;
  div_pkg::word_t    req_a;
  div_pkg::word_t    req_b;
  logic              resp_val;
  logic              resp_rdy;
  div_pkg::result_t  resp_result;

  logic [31:0]       rng_state;
  // 0 keeps resp_rdy high, 1 randomizes it, 2 holds it low
  int                rdy_mode;
  int                value_errors;
  int                other_errors;
  div_pkg::result_t  exp_queue[$];
  div_pkg::result_t  exp_front;
  logic              held;
  div_pkg::result_t  held_result;

  int_div_top i_int_div_top (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // helpers
  // --------------------

  // one xorshift32 step per call
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // mix of corner values, small values and full-range values
  function automatic div_pkg::word_t pick_operand();
    logic [31:0] sel;
    logic [31:0] v;
    sel = next_random();
    v   = next_random();
    case (sel[2:0])
      3'd0: return '0;
      3'd1: return '1;
      3'd2: return 32'h8000_0000;
      3'd3: return v & 32'hff;
      // small negative
      3'd4: return -(v & 32'hff);
      default: return v;
    endcase
  endfunction

  // reference model divides magnitudes and then applies the sign rules
  function automatic div_pkg::result_t model_divide(input div_pkg::div_fn_t fn,
                                                    input div_pkg::word_t a,
                                                    input div_pkg::word_t b);
    logic           a_neg;
    logic           b_neg;
    div_pkg::word_t a_abs;
    div_pkg::word_t b_abs;
    div_pkg::word_t q;
    div_pkg::word_t r;
    a_neg = (fn == div_pkg::fn_signed) && a[`DIV_WIDTH-1];
    b_neg = (fn == div_pkg::fn_signed) && b[`DIV_WIDTH-1];
    a_abs = a_neg ? -a : a;
    b_abs = b_neg ? -b : b;
    if (b_abs == '0) begin
      // zero divisor gives an all-ones quotient and leaves the dividend as remainder
      q = '1;
      r = a_abs;
    end else begin
      q = a_abs / b_abs;
      r = a_abs % b_abs;
    end
    if (a_neg != b_neg) begin
      q = -q;
    end
    if (a_neg) begin
      r = -r;
    end
    return {r, q};
  endfunction

  task automatic check_word(input string name, input div_pkg::word_t got,
                            input div_pkg::word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // --------------------
  // scoreboard
  // --------------------

  // sampled on the falling edge where inputs and outputs have settled
  always @(negedge clk) begin
    if (reset) begin
      held = 1'b0;
    end else begin
      // a stalled response must not move or vanish
      if (held) begin
        check_flag("resp_val", resp_val, 1'b1);
        check_word("resp_result quotient", resp_result[`DIV_WIDTH-1:0],
                   held_result[`DIV_WIDTH-1:0]);
        check_word("resp_result remainder", resp_result[2*`DIV_WIDTH-1:`DIV_WIDTH],
                   held_result[2*`DIV_WIDTH-1:`DIV_WIDTH]);
      end
      held        = resp_val && !resp_rdy;
      held_result = resp_result;
      // pop before push so a spurious response is never matched
      if (resp_val && resp_rdy) begin
        if (exp_queue.size() == 0) begin
          other_errors++;
          $display("a response arrived with no request outstanding at %0t", $time);
        end else begin
          exp_front = exp_queue.pop_front();
          check_word("quotient", resp_result[`DIV_WIDTH-1:0], exp_front[`DIV_WIDTH-1:0]);
          check_word("remainder", resp_result[2*`DIV_WIDTH-1:`DIV_WIDTH],
                     exp_front[2*`DIV_WIDTH-1:`DIV_WIDTH]);
        end
      end
      if (req_val && req_rdy) begin
        exp_queue.push_back(model_divide(req_fn, req_a, req_b));
      end
    end
  end

  // --------------------
  // stimulus
  // --------------------

  // step to just after the next rising edge and redraw resp_rdy
  task automatic next_cycle();
    @(posedge clk);
    #1;
    case (rdy_mode)
      0: resp_rdy = 1'b1;
      1: resp_rdy = (next_random() % 3) != 0;
      default: resp_rdy = 1'b0;
    endcase
  endtask

  // offer one request and hold it until it is taken
  task automatic send_request(input div_pkg::div_fn_t fn, input div_pkg::word_t a,
                              input div_pkg::word_t b);
    int   waited;
    logic taken;
    req_val = 1'b1;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    waited  = 0;
    taken   = 1'b0;
    while (!taken && waited < `DIV_TB_TIMEOUT) begin
      @(negedge clk);
      taken = req_rdy;
      waited++;
      next_cycle();
    end
    req_val = 1'b0;
    if (!taken) begin
      other_errors++;
      $display("request was not accepted within %0d cycles", `DIV_TB_TIMEOUT);
    end
  endtask

  // release the consumer and wait until every outstanding response is back
  task automatic drain_responses();
    int n;
    rdy_mode = 0;
    n = 0;
    while (exp_queue.size() != 0 && n < `DIV_TB_TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (exp_queue.size() != 0) begin
      other_errors++;
      $display("%0d responses never arrived", exp_queue.size());
    end
  endtask

  // isolated request on an empty unit with resp_rdy high
  task automatic measure_latency();
    int   cycles;
    logic seen;
    rdy_mode = 0;
    send_request(div_pkg::fn_signed, -32'd100, 32'd7);
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < `DIV_TB_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      seen = resp_val;
      next_cycle();
    end
    if (!seen) begin
      other_errors++;
      $display("no response within %0d cycles of an isolated request", `DIV_TB_TIMEOUT);
    end else begin
      // prep, DIV_STEPS calc cycles, core hand-off and fixup register
      check_word("response latency", div_pkg::word_t'(cycles),
                 div_pkg::word_t'(`DIV_STEPS + 3));
    end
  endtask

  // stall the consumer until every stage holds an entry
  task automatic fill_stages();
    int             n;
    logic           dropped;
    div_pkg::word_t a;
    div_pkg::word_t b;
    rdy_mode = 2;
    repeat (3) begin
      a = pick_operand();
      b = pick_operand();
      send_request(div_pkg::fn_signed, a, b);
    end
    n       = 0;
    dropped = 1'b0;
    while (!dropped && n < `DIV_TB_TIMEOUT) begin
      @(negedge clk);
      dropped = !req_rdy;
      n++;
      next_cycle();
    end
    if (!dropped) begin
      other_errors++;
      $display("req_rdy stayed high with all three stages full");
    end
    // the core finishes the second entry and waits in done
    repeat (`DIV_STEPS + 4) next_cycle();
    @(negedge clk);
    check_flag("req_rdy", req_rdy, 1'b0);
    check_flag("resp_val", resp_val, 1'b1);
    next_cycle();
  endtask

  initial begin
    int               i;
    int               gap;
    logic [31:0]      r;
    div_pkg::word_t   a;
    div_pkg::word_t   b;
    rng_state    = 32'h4fcf;
    rdy_mode     = 0;
    value_errors = 0;
    other_errors = 0;
    held         = 1'b0;
    reset        = 1'b1;
    req_val      = 1'b0;
    req_fn       = div_pkg::fn_unsigned;
    req_a        = '0;
    req_b        = '0;
    resp_rdy     = 1'b1;

    // reset state is checked after each reset edge
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      #1;
      check_flag("req_rdy", req_rdy, 1'b1);
      check_flag("resp_val", resp_val, 1'b0);
    end
    reset = 1'b0;
    @(negedge clk);
    check_flag("req_rdy", req_rdy, 1'b1);
    check_flag("resp_val", resp_val, 1'b0);
    next_cycle();

    measure_latency();

    // sign combinations and the most negative dividend
    rdy_mode = 1;
    send_request(div_pkg::fn_signed, 32'd7, 32'd2);
    send_request(div_pkg::fn_signed, -32'd7, 32'd2);
    send_request(div_pkg::fn_signed, 32'd7, -32'd2);
    send_request(div_pkg::fn_signed, -32'd7, -32'd2);
    send_request(div_pkg::fn_signed, 32'h8000_0000, -32'd1);
    send_request(div_pkg::fn_signed, 32'h8000_0000, 32'd3);
    send_request(div_pkg::fn_unsigned, 32'hffff_ffff, 32'd3);
    // divide by zero in both functions
    send_request(div_pkg::fn_unsigned, 32'd123, 32'd0);
    send_request(div_pkg::fn_unsigned, 32'h8000_0000, 32'd0);
    send_request(div_pkg::fn_signed, -32'd123, 32'd0);
    send_request(div_pkg::fn_signed, 32'h8000_0000, 32'd0);
    send_request(div_pkg::fn_signed, 32'd0, 32'd0);

    // random traffic with random gaps and consumer stalls
    for (i = 0; i < 120; i++) begin
      gap = next_random() % 4;
      repeat (gap) next_cycle();
      r = next_random();
      a = pick_operand();
      b = pick_operand();
      send_request(div_pkg::div_fn_t'(r[0]), a, b);
    end

    // the stall test needs an empty unit
    drain_responses();
    fill_stages();

    // drain whatever is still in flight
    drain_responses();

    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+include
design/div_pkg.sv
design/div_if.sv
design/div_operand_prep.sv
design/div_iter_core.sv
design/div_result_fixup.sv
design/int_div_top.sv
verif/int_div_tb.sv

//--- Bender.yml
package:
  name: int_div

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/div_pkg.sv
      - design/div_if.sv
      - design/div_operand_prep.sv
      - design/div_iter_core.sv
      - design/div_result_fixup.sv
      - design/int_div_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/int_div_tb.sv
